// File: bench/router_input_chk.sv
`timescale 1ns/100ps
`default_nettype none
`include "noc_defs.svh"

module router_input_chk
    import noc_types_pkg::*;
    import route_pkg::*;
(
    input logic       aclk,
    input logic       reset,
    input logic       pop,
    input port_idx_t  sel_port,
    input flit_t      head_flit,
    input flit_t      out_flit [`NOC_PORTS],
    input port_mask_t out_valid,
    input port_mask_t out_ready
);

    int        assert_errors = 0;
    logic      pkt_open;
    port_idx_t pkt_port;

    // Packet between its head pop and its last pop.
    always_ff @(posedge aclk) begin
        if (reset) begin
            pkt_open <= 1'b0;
            pkt_port <= '0;
        end else if (pop) begin
            pkt_open <= !head_flit.last;
            if (!pkt_open) begin
                pkt_port <= sel_port; // Port taken by the head.
            end
        end
    end

    single_load: assert property (@(posedge aclk) disable iff (reset)
        $onehot0(out_valid & ~$past(out_valid)))
    else begin
        assert_errors++;
        $error("More than one out_valid rose in one cycle");
    end

    for (genvar i = 0; i < `NOC_PORTS; i++) begin : g_hold
        hold_flit: assert property (@(posedge aclk) disable iff (reset)
            out_valid[i] && !out_ready[i] |=> out_valid[i] && $stable(out_flit[i]))
        else begin
            assert_errors++;
            $error("Port %0d changed its flit while stalled", i);
        end
    end

    // Body flits land on the head's port.
    lock_port: assert property (@(posedge aclk) disable iff (reset)
        pop && pkt_open |=> out_valid[pkt_port] && out_flit[pkt_port] == $past(head_flit))
    else begin
        assert_errors++;
        $error("Body flit did not reach port %0d", pkt_port);
    end

endmodule

bind router_input router_input_chk router_input_chk_inst (
    .aclk      (aclk),
    .reset     (reset),
    .pop       (pop),
    .sel_port  (sel_port),
    .head_flit (head_flit),
    .out_flit  (out_flit),
    .out_valid (out_valid),
    .out_ready (out_ready)
);

`default_nettype wire

// File: bench/router_input_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "noc_defs.svh"

module router_input_tb
    import noc_types_pkg::*;
    import route_pkg::*;
();

    localparam int router_x = 1;
    localparam int router_y = 2;
    localparam coord_x_t self_x = coord_x_t'(router_x);
    localparam coord_y_t self_y = coord_y_t'(router_y);

    // Packet ranges of the phases.
    localparam int n_directed = 7;
    localparam int end_all_ready = 27;
    localparam int end_random = 57;
    localparam int n_pkts = 61;

    // Local, east, west, north, south, then two diagonals.
    localparam int dir_x [n_directed] = '{1, 3, 0, 1, 1, 2, 0};
    localparam int dir_y [n_directed] = '{2, 2, 2, 0, 3, 1, 3};

    logic       aclk = 1'b0;
    logic       reset;
    flit_t      in_flit;
    logic       in_valid;
    logic       in_ready;
    flit_t      out_flit [`NOC_PORTS];
    port_mask_t out_valid;
    port_mask_t out_ready;

    flit_t exp_q [n_pkts][$];     // Expected flits per packet.
    int    exp_pos [n_pkts];      // Flits of the packet seen so far.
    int    port_pkt [`NOC_PORTS]; // Open packet per port, -1 when none.
    int    total_flits = 0;
    int    flits_in = 0;
    int    flits_out = 0;
    int    errors = 0;
    int    run_errors = 0;
    int    cycles = 0;
    int    limit = 0;
    int    ready_mode = 0;        // 0 all ready, 1 random, 2 stalled.
    logic  strict_port = 1'b0;
    logic  idle_check = 1'b0;
    logic  stall_seen = 1'b0;

    always #2 aclk = ~aclk;

    router_input #(
        .router_x (router_x),
        .router_y (router_y)
    ) router_input_inst (
        .aclk      (aclk),
        .reset     (reset),
        .in_flit   (in_flit),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_flit  (out_flit),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    // Minimal directions toward a target.
    function automatic port_mask_t ref_mask(input coord_x_t tx, input coord_y_t ty);
        port_mask_t m;
        m = '0;
        if (tx == self_x && ty == self_y) begin
            m[port_local] = 1'b1;
        end else begin
            m[port_east] = (tx > self_x);
            m[port_west] = (tx < self_x);
            m[port_north] = (ty < self_y);
            m[port_south] = (ty > self_y);
        end
        return m;
    endfunction

    // Port taken when every output slot is free.
    function automatic port_idx_t ref_port(input coord_x_t tx, input coord_y_t ty);
        if (tx == self_x && ty == self_y) begin
            return port_local;
        end else if (tx != self_x) begin
            return (tx > self_x) ? port_east : port_west;
        end
        return (ty < self_y) ? port_north : port_south;
    endfunction

    task automatic check_flit(input flit_t got, input flit_t exp, input string name);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_port(input port_idx_t got, input port_idx_t exp, input string name);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_mask(input port_mask_t got, input port_mask_t exp, input string name);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic take_flit(input int p, input flit_t f);
        int         id;
        flit_t      e;
        port_mask_t pbit;
        pbit = port_mask_t'(1) << p;
        flits_out++;
        if (port_pkt[p] < 0) begin
            id = int'(f.data[`NOC_DATA_WIDTH-1 -: 8]); // Head names its packet.
            if (id >= n_pkts || exp_pos[id] != 0) begin
                errors++;
                $display("Flit %h on port %0d at %0t matches no waiting packet", f, p, $time);
                return;
            end
            e = exp_q[id][0];
            check_mask(ref_mask(e.target_x, e.target_y) & pbit, pbit,
                       $sformatf("eligible bit of port %0d", p));
            if (strict_port) begin
                check_port(port_idx_t'(p), ref_port(e.target_x, e.target_y),
                           $sformatf("port of packet %0d", id));
            end
        end else begin
            id = port_pkt[p];
        end
        check_flit(f, exp_q[id][exp_pos[id]], $sformatf("out_flit[%0d]", p));
        exp_pos[id]++;
        port_pkt[p] = (exp_pos[id] < exp_q[id].size()) ? id : -1;
    endtask

    // Outputs are stable here, half a cycle after the last change.
    always @(negedge aclk) begin
        if (reset) begin
            for (int p = 0; p < `NOC_PORTS; p++) begin
                port_pkt[p] = -1;
            end
        end else begin
            if (idle_check) begin
                check_mask(out_valid, '0, "out_valid");
            end
            for (int p = 0; p < `NOC_PORTS; p++) begin
                if (out_valid[p] && out_ready[p]) begin
                    take_flit(p, out_flit[p]);
                end
            end
        end
    end

    task automatic build_packets();
        coord_x_t tx;
        coord_y_t ty;
        int       len;
        flit_t    f;
        for (int id = 0; id < n_pkts; id++) begin
            if (id < n_directed) begin
                tx = coord_x_t'(dir_x[id]);
                ty = coord_y_t'(dir_y[id]);
                len = 2;
            end else begin
                tx = coord_x_t'($urandom);
                ty = coord_y_t'($urandom);
                len = (id >= end_random) ? 4 : 1 + int'($urandom % 4);
            end
            for (int i = 0; i < len; i++) begin
                f.target_x = tx;
                f.target_y = ty;
                f.last = (i == len - 1);
                f.data = {8'(id), 8'(i), 16'($urandom)};
                exp_q[id].push_back(f);
                total_flits++;
            end
        end
    endtask

    task automatic send_flit(input flit_t f);
        in_flit = f;
        in_valid = 1'b1;
        @(negedge aclk);
        while (!in_ready) begin
            @(negedge aclk);
        end
        @(posedge aclk);
        #0.5;
        in_valid = 1'b0;
        flits_in++;
    endtask

    task automatic send_range(input int first, input int stop);
        for (int id = first; id < stop; id++) begin
            for (int i = 0; i < exp_q[id].size(); i++) begin
                send_flit(exp_q[id][i]);
            end
        end
    endtask

    task automatic drain();
        wait (flits_out == flits_in);
        @(posedge aclk);
        #0.5;
    endtask

    initial begin
        int mode;
        out_ready = '1;
        forever begin
            @(posedge aclk);
            mode = ready_mode;
            #0.5;
            case (mode)
                0: out_ready = '1;
                1: out_ready = port_mask_t'($urandom);
                default: out_ready = '0;
            endcase
        end
    end

    initial begin
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge aclk);
            cycles++;
        end
        $display("Timeout after %0d cycles, %0d of %0d flits out", cycles, flits_out, flits_in);
        $display("Test failed");
        $finish;
    end

    initial begin
        int fails;
        void'($urandom(32'h30b2));
        reset = 1'b1;
        in_flit = '0;
        in_valid = 1'b0;
        build_packets();
        limit = 40 * total_flits + 200;
        repeat (5) @(posedge aclk);
        #0.5;
        reset = 1'b0;

        idle_check = 1'b1;
        repeat (10) begin
            @(negedge aclk);
            if (!in_ready) begin
                run_errors++;
                $display("in_ready is low on an idle router at %0t", $time);
            end
        end
        @(posedge aclk);
        #0.5;
        idle_check = 1'b0;

        // All slots free, so every head takes the fixed priority port.
        strict_port = 1'b1;
        send_range(0, end_all_ready);
        drain();
        strict_port = 1'b0;

        ready_mode = 1;
        send_range(end_all_ready, end_random);
        drain();

        ready_mode = 2;
        fork
            send_range(end_random, n_pkts);
            begin
                for (int i = 0; i < 80 && !stall_seen; i++) begin
                    @(negedge aclk);
                    stall_seen = !in_ready;
                end
                repeat (8) @(posedge aclk);
                #0.5;
                ready_mode = 0; // Release the held flits.
            end
        join
        drain();
        if (!stall_seen) begin
            run_errors++;
            $display("in_ready never fell while every output was stalled");
        end

        for (int id = 0; id < n_pkts; id++) begin
            if (exp_pos[id] != exp_q[id].size()) begin
                run_errors++;
                $display("Packet %0d left %0d of %0d flits", id, exp_pos[id], exp_q[id].size());
            end
        end
        if (flits_out != flits_in) begin
            run_errors++;
            $display("Flit count differs, %0d in and %0d out", flits_in, flits_out);
        end

        fails = errors + run_errors + router_input_inst.router_input_chk_inst.assert_errors;
        $display("Errors: %0d compare, %0d run, %0d assertion; flits in %0d, out %0d",
                 errors, run_errors, router_input_inst.router_input_chk_inst.assert_errors,
                 flits_in, flits_out);
        if (fails == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: include/noc_defs.svh
`ifndef NOC_DEFS_SVH
`define NOC_DEFS_SVH

// Payload bits per flit.
`define NOC_DATA_WIDTH 32

// Mesh size in routers.
`define NOC_MAX_X 4
`define NOC_MAX_Y 4

// Local, north, east, south, west.
`define NOC_PORTS 5

// Input buffer entries.
`define FLIT_FIFO_DEPTH 4

`endif

// File: router_input.f
+incdir+include
source/noc_types_pkg.sv
source/route_pkg.sv
source/flit_buffer.sv
source/route_select.sv
source/port_demux.sv
source/router_input.sv
bench/router_input_chk.sv
bench/router_input_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the router input testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f router_input.f --top-module router_input_tb \
    -Mdir "$BUILD_DIR" -o router_input_sim
if [ $? -ne 0 ]; then
    echo "Verilator build did not complete"
    exit 1
fi

"$BUILD_DIR/router_input_sim" +verilator+error+limit+1000 > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG_FILE"; then
    exit 1
fi
if ! grep -q "Test passed" "$LOG_FILE"; then
    echo "Simulation log holds no result line"
    exit 1
fi
exit 0

// File: source/flit_buffer.sv
`timescale 1ns/100ps
`default_nettype none
`include "noc_defs.svh"

module flit_buffer
    import noc_types_pkg::*;
(
    input  logic  aclk,
    input  logic  reset,
    input  flit_t in_flit,
    input  logic  in_valid,
    output logic  in_ready,
    output flit_t head_flit,
    output logic  head_valid,
    input  logic  pop
);

    localparam int depth = `FLIT_FIFO_DEPTH;
    localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_width = $clog2(depth + 1);

    flit_t                mem [depth];
    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic [cnt_width-1:0] count;
    logic                 full;
    logic                 push;

    function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
        if (ptr == ptr_width'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full = (count == cnt_width'(depth));
    assign in_ready = !full || pop; // A pop frees the slot for this cycle's push.
    assign push = in_valid && in_ready;
    assign head_valid = (count != '0);
    assign head_flit = mem[rd_ptr];

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= in_flit;
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/noc_types_pkg.sv
`default_nettype none
`include "noc_defs.svh"

package noc_types_pkg;

    localparam int coord_x_width = $clog2(`NOC_MAX_X);
    localparam int coord_y_width = $clog2(`NOC_MAX_Y);

    typedef logic [coord_x_width-1:0] coord_x_t;
    typedef logic [coord_y_width-1:0] coord_y_t;

    // Target travels with every flit, only the head's is used for routing.
    typedef struct packed {
        coord_x_t                   target_x;
        coord_y_t                   target_y;
        logic                       last;     // Final flit of the packet.
        logic [`NOC_DATA_WIDTH-1:0] data;
    } flit_t;

endpackage

`default_nettype wire

// File: source/port_demux.sv
`timescale 1ns/100ps
`default_nettype none
`include "noc_defs.svh"

module port_demux
    import noc_types_pkg::*;
    import route_pkg::*;
(
    input  logic       aclk,
    input  logic       reset,
    input  flit_t      head_flit,
    input  logic       pop,
    input  port_idx_t  sel_port,
    output port_mask_t slot_free,
    output flit_t      out_flit [`NOC_PORTS],
    output port_mask_t out_valid,
    input  port_mask_t out_ready
);

    port_mask_t load;

    // Empty, or handing its flit over this cycle.
    assign slot_free = ~out_valid | out_ready;
    assign load = pop ? port_bit(sel_port) : '0;

    always_ff @(posedge aclk) begin
        for (int i = 0; i < `NOC_PORTS; i++) begin
            if (load[i]) begin
                out_flit[i] <= head_flit;
            end
        end
    end

    always_ff @(posedge aclk) begin
        for (int i = 0; i < `NOC_PORTS; i++) begin
            if (reset) begin
                out_valid[i] <= 1'b0;
            end else if (load[i]) begin
                out_valid[i] <= 1'b1;
            end else if (out_ready[i]) begin
                out_valid[i] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/route_pkg.sv
`default_nettype none
`include "noc_defs.svh"

package route_pkg;

    localparam int port_idx_width = $clog2(`NOC_PORTS);

    typedef logic [port_idx_width-1:0] port_idx_t;
    typedef logic [`NOC_PORTS-1:0] port_mask_t;

    // Port numbering of the router.
    localparam port_idx_t port_local = port_idx_t'(0);
    localparam port_idx_t port_north = port_idx_t'(1); // Toward smaller y.
    localparam port_idx_t port_east = port_idx_t'(2);  // Toward greater x.
    localparam port_idx_t port_south = port_idx_t'(3); // Toward greater y.
    localparam port_idx_t port_west = port_idx_t'(4);  // Toward smaller x.

    // One-hot mask of a single port.
    function automatic port_mask_t port_bit(input port_idx_t port);
        port_mask_t mask;
        mask = '0;
        mask[port] = 1'b1;
        return mask;
    endfunction

endpackage

`default_nettype wire

// File: source/route_select.sv
`timescale 1ns/100ps
`default_nettype none
`include "noc_defs.svh"

module route_select
    import noc_types_pkg::*;
    import route_pkg::*;
#(
    parameter int router_x = 0,
    parameter int router_y = 0
) (
    input  logic       aclk,
    input  logic       reset,
    input  flit_t      head_flit,
    input  logic       head_valid,
    input  port_mask_t slot_free,
    output port_idx_t  sel_port,
    output logic       sel_hit
);

    // Own position, folded into the mesh.
    localparam coord_x_t self_x = coord_x_t'(router_x % `NOC_MAX_X);
    localparam coord_y_t self_y = coord_y_t'(router_y % `NOC_MAX_Y);

    port_mask_t eligible;
    port_mask_t avail;
    port_idx_t  pick_port;
    logic       locked;
    port_idx_t  lock_port;
    logic       pop;

    // Minimal directions toward the head's target.
    always_comb begin
        eligible = '0;
        eligible[port_local] = (head_flit.target_x == self_x) &&
                               (head_flit.target_y == self_y);
        eligible[port_east] = (head_flit.target_x > self_x);
        eligible[port_west] = (head_flit.target_x < self_x);
        eligible[port_north] = (head_flit.target_y < self_y);
        eligible[port_south] = (head_flit.target_y > self_y);
    end

    assign avail = eligible & slot_free;

    // Local first, then the x axis, then the y axis.
    always_comb begin
        if (avail[port_local]) begin
            pick_port = port_local;
        end else if (avail[port_east]) begin
            pick_port = port_east;
        end else if (avail[port_west]) begin
            pick_port = port_west;
        end else if (avail[port_north]) begin
            pick_port = port_north;
        end else if (avail[port_south]) begin
            pick_port = port_south;
        end else begin
            pick_port = port_local;
        end
    end

    // Body flits follow the head's port and ignore their own target.
    always_comb begin
        if (locked) begin
            sel_port = lock_port;
            sel_hit = slot_free[lock_port];
        end else begin
            sel_port = pick_port;
            sel_hit = |avail;
        end
    end

    assign pop = head_valid && sel_hit;

    always_ff @(posedge aclk) begin
        if (reset) begin
            locked <= 1'b0;
            lock_port <= port_local;
        end else if (pop) begin
            locked <= !head_flit.last; // Released by the last flit.
            lock_port <= sel_port;
        end
    end

endmodule

`default_nettype wire

// File: source/router_input.sv
`timescale 1ns/100ps
`default_nettype none
`include "noc_defs.svh"

module router_input
    import noc_types_pkg::*;
    import route_pkg::*;
#(
    parameter int router_x = 0,
    parameter int router_y = 0
) (
    input  logic       aclk,
    input  logic       reset,
    input  flit_t      in_flit,
    input  logic       in_valid,
    output logic       in_ready,
    output flit_t      out_flit [`NOC_PORTS],
    output port_mask_t out_valid,
    input  port_mask_t out_ready
);

    flit_t      head_flit;
    logic       head_valid;
    port_idx_t  sel_port;
    logic       sel_hit;
    port_mask_t slot_free;
    logic       pop;

    assign pop = head_valid && sel_hit; // Shared by buffer and demux.

    flit_buffer flit_buffer_inst (
        .aclk       (aclk),
        .reset      (reset),
        .in_flit    (in_flit),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .head_flit  (head_flit),
        .head_valid (head_valid),
        .pop        (pop)
    );

    route_select #(
        .router_x (router_x),
        .router_y (router_y)
    ) route_select_inst (
        .aclk       (aclk),
        .reset      (reset),
        .head_flit  (head_flit),
        .head_valid (head_valid),
        .slot_free  (slot_free),
        .sel_port   (sel_port),
        .sel_hit    (sel_hit)
    );

    port_demux port_demux_inst (
        .aclk      (aclk),
        .reset     (reset),
        .head_flit (head_flit),
        .pop       (pop),
        .sel_port  (sel_port),
        .slot_free (slot_free),
        .out_flit  (out_flit),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire
